//--- hdl/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// word geometry
`define WORD_BITS 16         // data and instruction word

// address geometry
`define VADDR_BITS 10        // virtual address seen by the program
`define PADDR_BITS 10        // physical address on the memory port

// paging, top vaddr bits select the logical page
`define PAGE_OFFSET_BITS 6   // 64 words per page
`define PAGE_COUNT 16        // physical pages, same as logical pages

// register file
`define REG_COUNT 8          // general registers

// program image starts here, lower addresses are off limits
`define PROG_BASE 46         // also the reset pc

`endif

//--- hdl/core_pkg.sv
`include "core_settings.svh"

package core_pkg;

  typedef logic [`WORD_BITS-1:0] word_t;     // memory and register word
  typedef logic [`VADDR_BITS-1:0] vaddr_t;   // program address
  typedef logic [`PADDR_BITS-1:0] paddr_t;   // memory port address

  // logical or physical page number
  typedef logic [`VADDR_BITS-`PAGE_OFFSET_BITS-1:0] page_idx_t;

  // register number, low bits of the instruction register byte
  typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

  // opcodes carried in the high byte of word 0
  typedef enum logic [7:0] {
    op_jmp       = 8'd1,
    op_ram2reg   = 8'd2,
    op_reg2ram   = 8'd3,
    op_num2reg   = 8'd4,
    op_reg_plus  = 8'd5,
    op_reg_minus = 8'd6,
    op_exit      = 8'd17
  } opcode_t;

  typedef enum logic [1:0] {
    f_idle,   // waiting for retire or boot
    f_word0,  // opcode and register word requested
    f_word1   // operand word requested
  } fetch_state_t;

  typedef enum logic [1:0] {
    w_idle,
    w_walk,   // following the process chain
    w_alloc,  // scanning for a free page
    w_access  // read in flight
  } walk_state_t;

  typedef enum logic [1:0] {
    e_ready,
    e_mem_wait,
    e_halted
  } exec_state_t;

endpackage

//--- hdl/instr_fetch.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module instr_fetch (
  input  logic               clka,
  input  logic               rst,
  output logic               fetch_req,
  output core_pkg::vaddr_t   fetch_vaddr,
  input  logic               fetch_ack,
  input  core_pkg::word_t    rd_data,
  output logic               instr_valid,
  output core_pkg::opcode_t  instr_op,
  output core_pkg::reg_idx_t instr_reg,
  output core_pkg::word_t    instr_operand,
  input  logic               exec_done,
  input  logic               redirect,
  input  core_pkg::vaddr_t   redirect_target
);
  import core_pkg::*;

  fetch_state_t state;
  vaddr_t       pc;       // address of word 0 of the current instruction
  vaddr_t       next_pc;
  logic         boot;     // first fetch after reset still due

  always_comb begin
    if (!exec_done) begin
      next_pc = pc;  // boot fetch starts at the reset pc
    end else if (redirect) begin
      next_pc = redirect_target;
    end else begin
      next_pc = pc + vaddr_t'(2);  // two words per instruction
    end
  end

  always_ff @(posedge clka) begin
    fetch_req   <= 1'b0;
    instr_valid <= 1'b0;
    if (rst) begin
      state <= f_idle;
      pc    <= vaddr_t'(`PROG_BASE);
      boot  <= 1'b1;
    end else begin
      case (state)
        f_idle: begin
          if (boot || exec_done) begin
            pc          <= next_pc;
            fetch_vaddr <= next_pc;
            fetch_req   <= 1'b1;
            boot        <= 1'b0;
            state       <= f_word0;
          end
        end
        f_word0: begin
          if (fetch_ack) begin
            instr_op    <= opcode_t'(rd_data[`WORD_BITS-1 -: 8]);  // unknown codes run as no-op
            instr_reg   <= rd_data[$bits(reg_idx_t)-1:0];
            fetch_vaddr <= pc + vaddr_t'(1);
            fetch_req   <= 1'b1;
            state       <= f_word1;
          end
        end
        f_word1: begin
          if (fetch_ack) begin
            instr_operand <= rd_data;
            instr_valid   <= 1'b1;
            state         <= f_idle;
          end
        end
        default: state <= f_idle;
      endcase
    end
  end

  // decoded instruction only leaves after the walker has answered
  a_no_valid_in_flight: assert property (@(posedge clka) disable iff (rst)
    fetch_req |=> (!instr_valid until fetch_ack))
    else $error("instr_valid raised while a fetch is outstanding");

endmodule

//--- hdl/paged_mem_access.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module paged_mem_access (
  input  logic             clka,
  input  logic             rst,
  input  logic             fetch_req,
  input  core_pkg::vaddr_t fetch_vaddr,
  output logic             fetch_ack,
  input  logic             data_req,
  input  logic             data_we,
  input  core_pkg::vaddr_t data_vaddr,
  input  core_pkg::word_t  data_wdata,
  output logic             data_ack,
  output core_pkg::word_t  rd_data,
  output logic             mem_en,
  output logic             mem_we,
  output core_pkg::paddr_t mem_addr,
  output core_pkg::word_t  mem_wdata,
  input  core_pkg::word_t  mem_rdata
);
  import core_pkg::*;

  // page table, chain end points to itself
  page_idx_t next_ptr [`PAGE_COUNT];
  page_idx_t log_page [`PAGE_COUNT];
  logic      used     [`PAGE_COUNT];

  page_idx_t cache_lpage;  // last translation
  page_idx_t cache_ppage;

  walk_state_t state;
  page_idx_t   walk_ptr;   // chain entry under test, tail once the walk ends
  page_idx_t   scan_ptr;   // free page candidate
  logic        req_data;   // request came from execute
  logic        req_we;
  vaddr_t      req_vaddr;
  word_t       req_wdata;

  logic      cur_data;
  logic      cur_we;
  vaddr_t    cur_vaddr;
  word_t     cur_wdata;
  page_idx_t cur_lpage;
  logic      walk_match;
  logic      issue;        // translation known, strobe the memory
  page_idx_t issue_page;

  // new request is taken straight from the ports, later from the latch
  always_comb begin
    if (state == w_idle) begin
      cur_data  = data_req;
      cur_we    = data_req & data_we;
      cur_vaddr = data_req ? data_vaddr : fetch_vaddr;
      cur_wdata = data_wdata;
    end else begin
      cur_data  = req_data;
      cur_we    = req_we;
      cur_vaddr = req_vaddr;
      cur_wdata = req_wdata;
    end
  end

  assign cur_lpage = cur_vaddr[`VADDR_BITS-1:`PAGE_OFFSET_BITS];

  // logical page 0 lives at the chain head
  assign walk_match = (walk_ptr == '0) ? (cur_lpage == '0)
                                       : (log_page[walk_ptr] == cur_lpage);

  always_comb begin
    issue      = 1'b0;
    issue_page = cache_ppage;
    case (state)
      w_idle: issue = (fetch_req | data_req) && (cur_lpage == cache_lpage);
      w_walk: begin
        issue      = walk_match;
        issue_page = walk_ptr;
      end
      w_alloc: begin
        issue      = !used[scan_ptr];
        issue_page = scan_ptr;
      end
      default: issue = 1'b0;
    endcase
  end

  assign rd_data = mem_rdata;  // valid in the ack cycle of a read

  always_ff @(posedge clka) begin
    fetch_ack <= 1'b0;
    data_ack  <= 1'b0;
    mem_en    <= 1'b0;
    mem_we    <= 1'b0;
    if (rst) begin
      state       <= w_idle;
      cache_lpage <= '0;
      cache_ppage <= '0;
      next_ptr[0] <= '0;
      for (int i = 0; i < `PAGE_COUNT; i++) begin
        used[i] <= (i == 0);  // only the chain head is taken
      end
    end else begin
      case (state)
        w_idle: begin
          if (fetch_req || data_req) begin
            req_data  <= cur_data;
            req_we    <= cur_we;
            req_vaddr <= cur_vaddr;
            req_wdata <= cur_wdata;
            walk_ptr  <= '0;
            if (!issue) begin
              state <= w_walk;  // cache miss
            end
          end
        end
        w_walk: begin
          if (!walk_match) begin
            if (next_ptr[walk_ptr] == walk_ptr) begin
              scan_ptr <= page_idx_t'(1);  // page 0 is never free
              state    <= w_alloc;
            end else begin
              walk_ptr <= next_ptr[walk_ptr];
            end
          end
        end
        w_alloc: begin
          if (!used[scan_ptr]) begin
            used[scan_ptr]     <= 1'b1;
            log_page[scan_ptr] <= cur_lpage;
            next_ptr[scan_ptr] <= scan_ptr;  // new tail
            next_ptr[walk_ptr] <= scan_ptr;  // link behind old tail
          end else begin
            scan_ptr <= scan_ptr + 1'b1;
          end
        end
        w_access: begin
          fetch_ack <= !req_data;
          data_ack  <= req_data;
          state     <= w_idle;
        end
        default: state <= w_idle;
      endcase

      if (issue) begin
        mem_en      <= 1'b1;
        mem_we      <= cur_we;
        mem_addr    <= {issue_page, cur_vaddr[`PAGE_OFFSET_BITS-1:0]};
        mem_wdata   <= cur_wdata;
        cache_lpage <= cur_lpage;
        cache_ppage <= issue_page;
        if (cur_we) begin
          data_ack <= 1'b1;  // write done in its strobe cycle
          state    <= w_idle;
        end else begin
          state <= w_access;
        end
      end
    end
  end

  // fetch and execute must wait for the ack before the next request
  a_no_req_when_busy: assert property (@(posedge clka) disable iff (rst)
    (state != w_idle) |-> !(fetch_req || data_req))
    else $error("request arrived while the walker is busy");

  a_we_with_en: assert property (@(posedge clka) disable iff (rst)
    mem_we |-> mem_en)
    else $error("mem_we without mem_en");

  // logical pages never outnumber physical ones
  a_alloc_finds_page: assert property (@(posedge clka) disable iff (rst)
    $rose(state == w_alloc) |-> ##[1:`PAGE_COUNT] (state != w_alloc))
    else $error("allocation scan found no free page");

endmodule

//--- hdl/exec_unit.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module exec_unit (
  input  logic               clka,
  input  logic               rst,
  input  logic               instr_valid,
  input  core_pkg::opcode_t  instr_op,
  input  core_pkg::reg_idx_t instr_reg,
  input  core_pkg::word_t    instr_operand,
  output logic               exec_done,
  output logic               redirect,
  output core_pkg::vaddr_t   redirect_target,
  output logic               data_req,
  output logic               data_we,
  output core_pkg::vaddr_t   data_vaddr,
  output core_pkg::word_t    data_wdata,
  input  logic               data_ack,
  input  core_pkg::word_t    rd_data,
  output logic               halted
);
  import core_pkg::*;

  word_t       regs [`REG_COUNT];
  exec_state_t state;
  reg_idx_t    load_reg;  // destination of a pending ram2reg
  word_t       cur_val;
  logic        addr_ok;   // operand is inside the program area

  assign cur_val = regs[instr_reg];
  assign addr_ok = (instr_operand >= word_t'(`PROG_BASE));
  assign halted  = (state == e_halted);

  always_ff @(posedge clka) begin
    exec_done <= 1'b0;
    redirect  <= 1'b0;
    data_req  <= 1'b0;
    if (rst) begin
      state   <= e_ready;
      data_we <= 1'b0;
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else begin
      case (state)
        e_ready: begin
          if (instr_valid) begin
            case (instr_op)
              op_num2reg: begin
                regs[instr_reg] <= instr_operand;
                exec_done       <= 1'b1;
              end
              op_reg_plus: begin
                regs[instr_reg] <= cur_val + instr_operand;
                exec_done       <= 1'b1;
              end
              op_reg_minus: begin
                regs[instr_reg] <= cur_val - instr_operand;  // wraps at 16 bits
                exec_done       <= 1'b1;
              end
              op_jmp: begin
                redirect        <= addr_ok;  // low targets are ignored
                redirect_target <= instr_operand[`VADDR_BITS-1:0];
                exec_done       <= 1'b1;
              end
              op_ram2reg, op_reg2ram: begin
                if (addr_ok) begin
                  data_req   <= 1'b1;
                  data_we    <= (instr_op == op_reg2ram);
                  data_vaddr <= instr_operand[`VADDR_BITS-1:0];
                  data_wdata <= cur_val;
                  load_reg   <= instr_reg;
                  state      <= e_mem_wait;
                end else begin
                  exec_done <= 1'b1;
                end
              end
              op_exit: state <= e_halted;  // no retire, fetch stays parked
              default: exec_done <= 1'b1;
            endcase
          end
        end
        e_mem_wait: begin
          if (data_ack) begin
            if (!data_we) begin
              regs[load_reg] <= rd_data;
            end
            exec_done <= 1'b1;
            state     <= e_ready;
          end
        end
        default: state <= e_halted;
      endcase
    end
  end

  // fetch only hands over a new instruction after the previous retire
  a_valid_when_ready: assert property (@(posedge clka) disable iff (rst)
    instr_valid |-> (state == e_ready))
    else $error("instr_valid outside the ready state");

endmodule

//--- hdl/core_top.sv
`timescale 1ns/1ps

module core_top (
  input  logic             clka,
  input  logic             rst,
  output logic             mem_en,
  output logic             mem_we,
  output core_pkg::paddr_t mem_addr,
  output core_pkg::word_t  mem_wdata,
  input  core_pkg::word_t  mem_rdata,
  output logic             halted
);
  import core_pkg::*;

  logic     fetch_req;
  vaddr_t   fetch_vaddr;
  logic     fetch_ack;
  word_t    rd_data;      // shared read return for fetch and execute
  logic     instr_valid;
  opcode_t  instr_op;
  reg_idx_t instr_reg;
  word_t    instr_operand;
  logic     exec_done;
  logic     redirect;
  vaddr_t   redirect_target;
  logic     data_req;
  logic     data_we;
  vaddr_t   data_vaddr;
  word_t    data_wdata;
  logic     data_ack;

  instr_fetch u_fetch (
    .clka            (clka),
    .rst             (rst),
    .fetch_req       (fetch_req),
    .fetch_vaddr     (fetch_vaddr),
    .fetch_ack       (fetch_ack),
    .rd_data         (rd_data),
    .instr_valid     (instr_valid),
    .instr_op        (instr_op),
    .instr_reg       (instr_reg),
    .instr_operand   (instr_operand),
    .exec_done       (exec_done),
    .redirect        (redirect),
    .redirect_target (redirect_target)
  );

  paged_mem_access u_mmu (
    .clka        (clka),
    .rst         (rst),
    .fetch_req   (fetch_req),
    .fetch_vaddr (fetch_vaddr),
    .fetch_ack   (fetch_ack),
    .data_req    (data_req),
    .data_we     (data_we),
    .data_vaddr  (data_vaddr),
    .data_wdata  (data_wdata),
    .data_ack    (data_ack),
    .rd_data     (rd_data),
    .mem_en      (mem_en),
    .mem_we      (mem_we),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_rdata   (mem_rdata)
  );

  exec_unit u_exec (
    .clka            (clka),
    .rst             (rst),
    .instr_valid     (instr_valid),
    .instr_op        (instr_op),
    .instr_reg       (instr_reg),
    .instr_operand   (instr_operand),
    .exec_done       (exec_done),
    .redirect        (redirect),
    .redirect_target (redirect_target),
    .data_req        (data_req),
    .data_we         (data_we),
    .data_vaddr      (data_vaddr),
    .data_wdata      (data_wdata),
    .data_ack        (data_ack),
    .rd_data         (rd_data),
    .halted          (halted)
  );

endmodule

//--- testbench/tb_memory.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module tb_memory (
  input  logic                    clka,
  input  logic                    en,
  input  logic                    we,
  input  logic [`PADDR_BITS-1:0]  addr,
  input  logic [`WORD_BITS-1:0]   wdata,
  output logic [`WORD_BITS-1:0]   rdata
);

  localparam int DEPTH = 1 << `PADDR_BITS;

  logic [`WORD_BITS-1:0] mem [DEPTH];
  int write_count;  // writes seen since time 0

  // every word differs, so a wrong address shows up as a wrong value
  function automatic logic [`WORD_BITS-1:0] fill_word(input int a);
    logic [`WORD_BITS-1:0] w;
    w = `WORD_BITS'(a);
    return {w[7:0], w[15:8]} ^ (w * 16'd37) ^ 16'hc3a5;
  endfunction

  initial begin
    write_count = 0;
    rdata       = '0;
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = fill_word(i);
    end
  end

  // single port, read data one cycle after the strobe
  always @(posedge clka) begin
    if (en) begin
      if (we) begin
        mem[addr]   <= wdata;
        write_count <= write_count + 1;
      end else begin
        rdata <= mem[addr];
      end
    end
  end

  // program loader used by the testbench before reset ends
  task automatic load_word(input int a, input logic [`WORD_BITS-1:0] w);
    mem[a] = w;
  endtask

endmodule

//--- testbench/core_tb.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module core_tb;
  import core_pkg::*;

  localparam int N_INSTR = 10;
  localparam int PB = `PROG_BASE;

  logic clka;
  logic rst;
  logic mem_en;
  logic mem_we;
  paddr_t mem_addr;
  word_t mem_wdata;
  word_t mem_rdata;
  logic halted;

  int errors;
  int wr_idx;         // writes seen on the memory port
  int n_exp;
  logic seen_access;  // first strobe has happened
  paddr_t exp_addr [8];
  word_t exp_data [8];

  logic [7:0] prog_op [N_INSTR];
  reg_idx_t prog_reg [N_INSTR];
  word_t prog_arg [N_INSTR];

  // reference state
  int page_map [`PAGE_COUNT];
  int next_page;
  word_t sregs [`REG_COUNT];
  word_t shadow [1 << `PADDR_BITS];

  core_top core_i (
    .clka      (clka),
    .rst       (rst),
    .mem_en    (mem_en),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata),
    .halted    (halted)
  );

  tb_memory mem_model_i (
    .clka  (clka),
    .en    (mem_en),
    .we    (mem_we),
    .addr  (mem_addr),
    .wdata (mem_wdata),
    .rdata (mem_rdata)
  );

  initial begin
    clka = 1'b0;
    forever #5 clka = ~clka;
  end

  always @(posedge clka) begin
    if (rst) begin
      wr_idx      <= 0;
      seen_access <= 1'b0;
    end else if (mem_en) begin
      seen_access <= 1'b1;
      if (mem_we) wr_idx <= wr_idx + 1;
    end
  end

  a_reset_quiet: assert property (@(posedge clka) (rst && $past(rst)) |->
    (!mem_en && !mem_we && !halted))
    else begin
      errors++;
      $display("FAIL %0t outputs active during reset", $time);
    end

  a_quiet_until_fetch: assert property (@(posedge clka) disable iff (rst)
    !seen_access |-> (!halted && !mem_we))
    else begin
      errors++;
      $display("FAIL %0t write or halt before the first fetch", $time);
    end

  a_first_read: assert property (@(posedge clka) disable iff (rst)
    (mem_en && !seen_access) |-> (!mem_we && mem_addr == paddr_t'(PB)))
    else begin
      errors++;
      $display("FAIL %0t first access %0d is not a read of the program base",
        $time, mem_addr);
    end

  a_write_expected: assert property (@(posedge clka) disable iff (rst)
    (mem_en && mem_we) |-> (wr_idx < n_exp && mem_addr == exp_addr[wr_idx] &&
    mem_wdata == exp_data[wr_idx]))
    else begin
      errors++;
      $display("FAIL %0t write %0d to %0d data %h does not match the model",
        $time, wr_idx, mem_addr, mem_wdata);
    end

  a_silent_after_halt: assert property (@(posedge clka) disable iff (rst)
    halted |-> !mem_en)
    else begin
      errors++;
      $display("FAIL %0t memory strobe after halt", $time);
    end

  // physical address of a virtual one, first touch takes the next page
  task automatic translate(input int vaddr, output int paddr);
    int lp;
    lp = vaddr >> `PAGE_OFFSET_BITS;
    if (page_map[lp] < 0) begin
      page_map[lp] = next_page;
      next_page++;
    end
    paddr = (page_map[lp] << `PAGE_OFFSET_BITS) + (vaddr % (1 << `PAGE_OFFSET_BITS));
  endtask

  task automatic run_model();
    int pc;
    int nxt;
    int idx;
    int pa;
    int arg;
    reg_idx_t r;
    logic done;
    pc = PB;
    done = 1'b0;
    for (int i = 0; i < `PAGE_COUNT; i++) page_map[i] = -1;
    page_map[0] = 0;
    next_page = 1;
    for (int step = 0; step < 4 * N_INSTR && !done; step++) begin
      idx = (pc - PB) / 2;
      translate(pc, pa);
      translate(pc + 1, pa);
      r = prog_reg[idx];
      arg = prog_arg[idx];
      nxt = pc + 2;
      case (prog_op[idx])
        8'd4: sregs[r] = prog_arg[idx];
        8'd5: sregs[r] = sregs[r] + prog_arg[idx];
        8'd6: sregs[r] = sregs[r] - prog_arg[idx];
        8'd1: if (arg >= PB) nxt = arg;
        8'd2: if (arg >= PB) begin
          translate(arg, pa);
          sregs[r] = shadow[pa];
        end
        8'd3: if (arg >= PB) begin
          translate(arg, pa);
          shadow[pa] = sregs[r];
          exp_addr[n_exp] = paddr_t'(pa);
          exp_data[n_exp] = sregs[r];
          n_exp++;
        end
        8'd17: done = 1'b1;
        default: ;
      endcase
      pc = nxt;
    end
  endtask

  task automatic set_instr(input int i, input logic [7:0] op, input reg_idx_t r, input word_t a);
    prog_op[i] = op;
    prog_reg[i] = r;
    prog_arg[i] = a;
  endtask

  initial begin
    int cycles;
    int pa;
    void'($urandom(32'h05bf_ce19));
    errors = 0;
    n_exp = 0;
    rst = 1'b1;
    for (int i = 0; i < `REG_COUNT; i++) sregs[i] = '0;
    set_instr(0, 8'd4, 3'd1, word_t'($urandom));
    set_instr(1, 8'd5, 3'd1, word_t'($urandom));
    set_instr(2, 8'd6, 3'd1, word_t'($urandom));
    set_instr(3, 8'd3, 3'd1, 16'd324);   // logical page 5
    set_instr(4, 8'd3, 3'd1, 16'd199);   // logical page 3
    set_instr(5, 8'd1, 3'd0, 16'd10);    // jump below the base
    set_instr(6, 8'd3, 3'd1, 16'd20);    // store below the base
    set_instr(7, 8'd2, 3'd2, 16'd199);
    set_instr(8, 8'd3, 3'd2, 16'd330);   // page 5 again
    set_instr(9, 8'd17, 3'd0, 16'd0);
    run_model();
    #1;
    // program words sit where the chain walk maps their virtual address
    for (int i = 0; i < N_INSTR; i++) begin
      translate(PB + 2 * i, pa);
      mem_model_i.load_word(pa, {prog_op[i], 5'd0, prog_reg[i]});
      translate(PB + 2 * i + 1, pa);
      mem_model_i.load_word(pa, prog_arg[i]);
    end
    repeat (10) @(posedge clka);
    #1 rst = 1'b0;
    cycles = 0;
    while (!halted && cycles < 2000) begin
      @(posedge clka);
      cycles++;
    end
    if (!halted) begin
      errors++;
      $display("timeout: halted never rose after the exit instruction");
    end else begin
      repeat (20) @(posedge clka);
      if (mem_model_i.write_count != n_exp) begin
        errors++;
        $display("FAIL %0t saw %0d writes, model expects %0d",
          $time, mem_model_i.write_count, n_exp);
      end
    end
    $display("errors: %0d, writes checked: %0d of %0d", errors, wr_idx, n_exp);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+hdl
hdl/core_pkg.sv
hdl/instr_fetch.sv
hdl/paged_mem_access.sv
hdl/exec_unit.sv
hdl/core_top.sv
testbench/tb_memory.sv
testbench/core_tb.sv

//--- Bender.yml
package:
  name: paged_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/core_pkg.sv
      - hdl/instr_fetch.sv
      - hdl/paged_mem_access.sv
      - hdl/exec_unit.sv
      - hdl/core_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/tb_memory.sv
      - testbench/core_tb.sv
